//--- logic/flow_consts.svh
`ifndef FLOW_CONSTS_SVH
`define FLOW_CONSTS_SVH

`define WORD_WIDTH 16

`define GPR_COUNT 8 // General registers only, T and RA apart

`define RESET_PC 16'h0000

`endif

//--- logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [15:0] instr_t;

	typedef enum logic [4:0] {
		OPC_NOP      = 5'b00001,
		OPC_B        = 5'b00010,
		OPC_BEQZ     = 5'b00100,
		OPC_BNEZ     = 5'b00101,
		OPC_BTEQZ    = 5'b01100,
		OPC_LI       = 5'b01101,
		OPC_CMPI     = 5'b01110,
		OPC_JR_GROUP = 5'b11101
	} opcode_t;

	// Register-immediate layout shared by most encodings
	typedef struct packed {
		opcode_t    opcode;
		logic [2:0] rx;
		logic [7:0] imm8;
	} ri_fmt_t;

	localparam logic [7:0]  JR_FUNCT   = 8'b00000000;
	localparam logic [7:0]  JALR_FUNCT = 8'b11000000;
	localparam logic [10:0] JRRA_BITS  = 11'b00000100000; // Whole low field, rx included

	typedef enum logic [3:0] {
		OP_NOP,
		OP_B,
		OP_BEQZ,
		OP_BNEZ,
		OP_BTEQZ,
		OP_JR,
		OP_JALR,
		OP_JRRA,
		OP_LI,
		OP_CMPI
	} op_kind_t;

endpackage

`default_nettype wire

//--- logic/core_pkg.sv
`default_nettype none
`include "flow_consts.svh"

package core_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t; // Data word and pc

	typedef logic [$clog2(`GPR_COUNT)-1:0] reg_idx_t;

	typedef enum logic [1:0] {
		WB_NONE,
		WB_GPR,
		WB_T,
		WB_RA
	} wb_target_t;

endpackage

`default_nettype wire

//--- logic/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode import isa_pkg::*, core_pkg::*; (
	input  instr_t   instr,
	output op_kind_t op_kind,
	output reg_idx_t rx,
	output word_t    imm_sext8,
	output word_t    imm_zext8,
	output word_t    offset_sext11
);

	ri_fmt_t     fmt;
	logic [10:0] offset11;

	assign fmt = ri_fmt_t'(instr);
	assign offset11 = instr[10:0]; // B uses the whole low field

	assign rx = fmt.rx;
	assign imm_zext8 = word_t'(fmt.imm8);
	assign imm_sext8 = {{($bits(word_t) - 8){fmt.imm8[7]}}, fmt.imm8};
	assign offset_sext11 = {{($bits(word_t) - 11){offset11[10]}}, offset11};

	always_comb begin
		op_kind = OP_NOP; // Unmatched encodings fall through as no-ops
		case (fmt.opcode)
			OPC_NOP: begin
				op_kind = OP_NOP;
			end
			OPC_B: begin
				op_kind = OP_B;
			end
			OPC_BEQZ: begin
				op_kind = OP_BEQZ;
			end
			OPC_BNEZ: begin
				op_kind = OP_BNEZ;
			end
			OPC_BTEQZ: begin
				if (fmt.rx == 3'b000) begin
					op_kind = OP_BTEQZ;
				end
			end
			OPC_LI: begin
				op_kind = OP_LI;
			end
			OPC_CMPI: begin
				op_kind = OP_CMPI;
			end
			OPC_JR_GROUP: begin
				if (fmt.imm8 == JR_FUNCT) begin
					op_kind = OP_JR;
				end else if (fmt.imm8 == JALR_FUNCT) begin
					op_kind = OP_JALR;
				end else if (offset11 == JRRA_BITS) begin
					op_kind = OP_JRRA;
				end
			end
			default: begin
				op_kind = OP_NOP;
			end
		endcase
	end

	// Undriven instr bits must not leak into control flow
	always_comb begin
		assert final (!$isunknown(op_kind))
			else $error("instr_decode: op_kind is unknown");
	end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "flow_consts.svh"

module reg_file import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  reg_idx_t   rd_idx,
	output word_t      rd_value,
	output logic       t_flag,
	output word_t      ra_value,
	input  wb_target_t wr_target,
	input  reg_idx_t   wr_idx,
	input  word_t      wr_value
);

	word_t gpr [`GPR_COUNT];
	logic  t_reg;
	word_t ra_reg;

	assign rd_value = gpr[rd_idx]; // Combinational read
	assign t_flag = t_reg;
	assign ra_value = ra_reg;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `GPR_COUNT; i++) begin
				gpr[i] <= '0;
			end
			t_reg <= 1'b0;
			ra_reg <= '0;
		end else begin
			case (wr_target)
				WB_GPR: begin
					gpr[wr_idx] <= wr_value;
				end
				WB_T: begin
					t_reg <= wr_value[0]; // Only bit 0 is kept
				end
				WB_RA: begin
					ra_reg <= wr_value;
				end
				default: begin
				end
			endcase
		end
	end

	// Fetch must not hand over an instruction while in reset
	assert property (@(posedge clk) !rst_n |-> wr_target == WB_NONE)
		else $error("reg_file: write requested during reset");

endmodule

`default_nettype wire

//--- logic/jmp_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module jmp_ctrl import isa_pkg::*, core_pkg::*; (
	input  op_kind_t op_kind,
	input  word_t    op1,
	input  logic     t_flag,
	input  word_t    ra_value,
	input  word_t    pc,
	input  word_t    imm_sext8,
	input  word_t    offset_sext11,
	output logic     set_pc,
	output word_t    set_pc_value,
	output logic     write_ra,
	output word_t    write_ra_value
);

	word_t pc_inc;
	word_t branch_target;
	logic  cond_taken;

	assign pc_inc = pc + 1'b1;
	assign branch_target = pc_inc + imm_sext8; // Conditional branches, 8-bit offset
	assign write_ra_value = pc_inc;

	always_comb begin
		case (op_kind)
			OP_BEQZ:  cond_taken = (op1 == '0);
			OP_BNEZ:  cond_taken = (op1 != '0);
			OP_BTEQZ: cond_taken = !t_flag;
			default:  cond_taken = 1'b0;
		endcase
	end

	always_comb begin
		set_pc = 1'b0;
		set_pc_value = '0;
		write_ra = 1'b0;
		case (op_kind)
			OP_B: begin
				set_pc = 1'b1;
				set_pc_value = pc_inc + offset_sext11;
			end
			OP_BEQZ, OP_BNEZ, OP_BTEQZ: begin
				if (cond_taken) begin
					set_pc = 1'b1;
					set_pc_value = branch_target;
				end
			end
			OP_JR: begin
				set_pc = 1'b1;
				set_pc_value = op1;
			end
			OP_JALR: begin
				set_pc = 1'b1;
				set_pc_value = op1;
				write_ra = 1'b1; // Link
			end
			OP_JRRA: begin
				set_pc = 1'b1;
				set_pc_value = ra_value;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		assert final (!write_ra || set_pc)
			else $error("jmp_ctrl: RA link without a jump");
	end

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "flow_consts.svh"

module fetch_unit import isa_pkg::*, core_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       instr_valid,
	output logic       instr_ready,
	output word_t      fetch_pc,
	input  op_kind_t   op_kind,
	input  reg_idx_t   rx,
	input  word_t      rd_value,
	input  word_t      imm_sext8,
	input  word_t      imm_zext8,
	input  logic       set_pc,
	input  word_t      set_pc_value,
	input  logic       write_ra,
	input  word_t      write_ra_value,
	output wb_target_t rf_wr_target,
	output reg_idx_t   rf_wr_idx,
	output word_t      rf_wr_value,
	output logic       retire_valid,
	input  logic       retire_ready,
	output word_t      retire_pc,
	output word_t      retire_next_pc,
	output wb_target_t retire_wb_target,
	output reg_idx_t   retire_wb_reg,
	output word_t      retire_wb_value
);

	logic       accept;
	word_t      next_pc;
	wb_target_t wb_target;
	reg_idx_t   wb_reg;
	word_t      wb_value;

	assign instr_ready = !retire_valid || retire_ready; // Slot free or draining now
	assign accept = instr_valid && instr_ready;
	assign next_pc = set_pc ? set_pc_value : fetch_pc + 1'b1;

	always_comb begin
		wb_target = WB_NONE;
		wb_value = '0;
		case (op_kind)
			OP_LI: begin
				wb_target = WB_GPR;
				wb_value = imm_zext8;
			end
			OP_CMPI: begin
				wb_target = WB_T;
				wb_value = word_t'(rd_value != imm_sext8); // T clear on equal
			end
			default: begin
				if (write_ra) begin
					wb_target = WB_RA;
					wb_value = write_ra_value;
				end
			end
		endcase
	end

	assign wb_reg = (wb_target == WB_GPR) ? rx : '0;

	assign rf_wr_target = accept ? wb_target : WB_NONE;
	assign rf_wr_idx = wb_reg;
	assign rf_wr_value = wb_value;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_pc <= `RESET_PC;
			retire_valid <= 1'b0;
		end else if (accept) begin
			fetch_pc <= next_pc;
			retire_valid <= 1'b1;
		end else if (retire_ready) begin
			retire_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			retire_pc <= fetch_pc;
			retire_next_pc <= next_pc;
			retire_wb_target <= wb_target;
			retire_wb_reg <= wb_reg;
			retire_wb_value <= wb_value;
		end
	end

	// A stalled record must reach the consumer unchanged
	assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid && !retire_ready |=> retire_valid
			&& $stable(retire_pc) && $stable(retire_next_pc)
			&& $stable(retire_wb_target) && $stable(retire_wb_reg)
			&& $stable(retire_wb_value))
		else $error("fetch_unit: retire record changed under back-pressure");

endmodule

`default_nettype wire

//--- logic/flow_core.sv
`timescale 1ns/1ps
`default_nettype none

module flow_core import isa_pkg::*, core_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  instr_t     instr,
	input  logic       instr_valid,
	output logic       instr_ready,
	output word_t      fetch_pc,
	output logic       retire_valid,
	input  logic       retire_ready,
	output word_t      retire_pc,
	output word_t      retire_next_pc,
	output wb_target_t retire_wb_target,
	output reg_idx_t   retire_wb_reg,
	output word_t      retire_wb_value
);

	op_kind_t   op_kind;
	reg_idx_t   rx;
	word_t      imm_sext8;
	word_t      imm_zext8;
	word_t      offset_sext11;
	word_t      rd_value;
	logic       t_flag;
	word_t      ra_value;
	logic       set_pc;
	word_t      set_pc_value;
	logic       write_ra;
	word_t      write_ra_value;
	wb_target_t rf_wr_target;
	reg_idx_t   rf_wr_idx;
	word_t      rf_wr_value;

	instr_decode u_decode (
		.instr         (instr),
		.op_kind       (op_kind),
		.rx            (rx),
		.imm_sext8     (imm_sext8),
		.imm_zext8     (imm_zext8),
		.offset_sext11 (offset_sext11)
	);

	reg_file u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_idx    (rx),
		.rd_value  (rd_value),
		.t_flag    (t_flag),
		.ra_value  (ra_value),
		.wr_target (rf_wr_target),
		.wr_idx    (rf_wr_idx),
		.wr_value  (rf_wr_value)
	);

	jmp_ctrl u_jmp (
		.op_kind        (op_kind),
		.op1            (rd_value),
		.t_flag         (t_flag),
		.ra_value       (ra_value),
		.pc             (fetch_pc), // pc of the instruction on the port
		.imm_sext8      (imm_sext8),
		.offset_sext11  (offset_sext11),
		.set_pc         (set_pc),
		.set_pc_value   (set_pc_value),
		.write_ra       (write_ra),
		.write_ra_value (write_ra_value)
	);

	fetch_unit u_fetch (
		.clk              (clk),
		.rst_n            (rst_n),
		.instr_valid      (instr_valid),
		.instr_ready      (instr_ready),
		.fetch_pc         (fetch_pc),
		.op_kind          (op_kind),
		.rx               (rx),
		.rd_value         (rd_value),
		.imm_sext8        (imm_sext8),
		.imm_zext8        (imm_zext8),
		.set_pc           (set_pc),
		.set_pc_value     (set_pc_value),
		.write_ra         (write_ra),
		.write_ra_value   (write_ra_value),
		.rf_wr_target     (rf_wr_target),
		.rf_wr_idx        (rf_wr_idx),
		.rf_wr_value      (rf_wr_value),
		.retire_valid     (retire_valid),
		.retire_ready     (retire_ready),
		.retire_pc        (retire_pc),
		.retire_next_pc   (retire_next_pc),
		.retire_wb_target (retire_wb_target),
		.retire_wb_reg    (retire_wb_reg),
		.retire_wb_value  (retire_wb_value)
	);

endmodule

`default_nettype wire

//--- sim/flow_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "flow_consts.svh"

module flow_core_tb import isa_pkg::*, core_pkg::*; ();

	typedef struct packed {
		word_t      pc;
		word_t      next_pc;
		wb_target_t tgt;
		reg_idx_t   wreg;
		word_t      val;
	} retire_rec_t;

	logic       clk;
	logic       rst_n;
	instr_t     instr;
	logic       instr_valid;
	logic       instr_ready;
	word_t      fetch_pc;
	logic       retire_valid;
	logic       retire_ready;
	word_t      retire_pc;
	word_t      retire_next_pc;
	wb_target_t retire_wb_target;
	reg_idx_t   retire_wb_reg;
	word_t      retire_wb_value;

	instr_t      mem [1024]; // Program memory, indexed by fetch_pc[9:0]
	word_t       model_pc;
	word_t       model_gpr [`GPR_COUNT];
	logic        model_t;
	word_t       model_ra;
	retire_rec_t exp_q [$];

	flow_core uut (
		.clk              (clk),
		.rst_n            (rst_n),
		.instr            (instr),
		.instr_valid      (instr_valid),
		.instr_ready      (instr_ready),
		.fetch_pc         (fetch_pc),
		.retire_valid     (retire_valid),
		.retire_ready     (retire_ready),
		.retire_pc        (retire_pc),
		.retire_next_pc   (retire_next_pc),
		.retire_wb_target (retire_wb_target),
		.retire_wb_reg    (retire_wb_reg),
		.retire_wb_value  (retire_wb_value)
	);

	always #2 clk = ~clk;

	task automatic report_failure();
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_target(input string name, input wb_target_t got, input wb_target_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			report_failure();
		end
	endtask

	function automatic instr_t li_word(input reg_idx_t r, input logic [7:0] imm);
		li_word = {5'b01101, r, imm};
	endfunction

	function automatic instr_t cmpi_word(input reg_idx_t r, input logic [7:0] imm);
		cmpi_word = {5'b01110, r, imm};
	endfunction

	function automatic instr_t b_word(input int off);
		b_word = {5'b00010, off[10:0]};
	endfunction

	function automatic instr_t beqz_word(input reg_idx_t r, input int off);
		beqz_word = {5'b00100, r, off[7:0]};
	endfunction

	function automatic instr_t bnez_word(input reg_idx_t r, input int off);
		bnez_word = {5'b00101, r, off[7:0]};
	endfunction

	function automatic instr_t bteqz_word(input int off);
		bteqz_word = {5'b01100, 3'b000, off[7:0]};
	endfunction

	function automatic instr_t jr_word(input reg_idx_t r);
		jr_word = {5'b11101, r, 8'h00};
	endfunction

	function automatic instr_t jalr_word(input reg_idx_t r);
		jalr_word = {5'b11101, r, 8'hc0};
	endfunction

	function automatic instr_t jrra_word();
		jrra_word = {5'b11101, 11'b000_0010_0000};
	endfunction

	task automatic place(input word_t addr, input instr_t ins);
		mem[addr[9:0]] = ins;
	endtask

	// Reference model of one accepted instruction
	task automatic predict(input instr_t ins);
		retire_rec_t rec;
		reg_idx_t    r;
		logic [7:0]  imm8;
		word_t       pc1;
		word_t       sext8;
		word_t       sext11;
		word_t       opnd;
		r = ins[10:8];
		imm8 = ins[7:0];
		pc1 = model_pc + 16'd1;
		sext8 = {{8{imm8[7]}}, imm8};
		sext11 = {{5{ins[10]}}, ins[10:0]};
		opnd = model_gpr[r];
		rec.pc = model_pc;
		rec.next_pc = pc1;
		rec.tgt = WB_NONE;
		rec.wreg = '0;
		rec.val = '0;
		case (ins[15:11])
			5'b00010: rec.next_pc = pc1 + sext11;
			5'b00100: if (opnd == 16'h0000) rec.next_pc = pc1 + sext8;
			5'b00101: if (opnd != 16'h0000) rec.next_pc = pc1 + sext8;
			5'b01100: if (r == 3'b000 && !model_t) rec.next_pc = pc1 + sext8;
			5'b01101: begin
				rec.tgt = WB_GPR;
				rec.wreg = r;
				rec.val = {8'h00, imm8};
				model_gpr[r] = rec.val;
			end
			5'b01110: begin
				rec.tgt = WB_T;
				rec.val = (opnd == sext8) ? 16'h0000 : 16'h0001; // T clear on equal
				model_t = rec.val[0];
			end
			5'b11101: begin
				if (imm8 == 8'h00) begin
					rec.next_pc = opnd;
				end else if (imm8 == 8'hc0) begin
					rec.next_pc = opnd;
					rec.tgt = WB_RA;
					rec.val = pc1;
					model_ra = pc1;
				end else if (ins[10:0] == 11'h020) begin
					rec.next_pc = model_ra;
				end
			end
			default: begin
			end
		endcase
		model_pc = rec.next_pc;
		exp_q.push_back(rec);
	endtask

	task automatic compare_record();
		retire_rec_t rec;
		rec = exp_q.pop_front();
		check_word("retire_pc", retire_pc, rec.pc);
		check_word("retire_next_pc", retire_next_pc, rec.next_pc);
		check_target("retire_wb_target", retire_wb_target, rec.tgt);
		check_reg("retire_wb_reg", retire_wb_reg, rec.wreg);
		check_word("retire_wb_value", retire_wb_value, rec.val);
	endtask

	// One clock cycle, inputs driven on the falling edge
	task automatic drive_cycle(input bit issue, input bit rdy, output bit accepted);
		bit busy;
		@(negedge clk);
		busy = (exp_q.size() != 0);
		check_bit("retire_valid", retire_valid, busy);
		retire_ready = rdy;
		if (busy && rdy) begin
			compare_record(); // Leaves at the next rising edge
		end
		accepted = 1'b0;
		if (issue) begin
			check_word("fetch_pc", fetch_pc, model_pc);
			instr = mem[fetch_pc[9:0]];
			instr_valid = 1'b1;
			if (!busy || rdy) begin
				predict(mem[model_pc[9:0]]);
				accepted = 1'b1;
			end
		end else begin
			instr_valid = 1'b0;
		end
		#1;
		check_bit("instr_ready", instr_ready, !busy || rdy);
	endtask

	task automatic run_program(input int count, input int ready_pct);
		int issued;
		int cycles;
		bit rdy;
		bit accepted;
		issued = 0;
		cycles = 0;
		while (issued < count || exp_q.size() != 0) begin
			if (cycles > 20 * count + 20) begin
				$display("Timeout: %0d instructions did not all retire within %0d cycles",
					count, cycles);
				report_failure();
			end
			rdy = (($urandom % 100) < ready_pct);
			drive_cycle(issued < count, rdy, accepted);
			if (accepted) begin
				issued++;
			end
			cycles++;
		end
		check_word("fetch_pc", fetch_pc, model_pc);
	endtask

	task automatic reset_values();
		@(negedge clk);
		check_word("fetch_pc", fetch_pc, `RESET_PC);
		check_bit("instr_ready", instr_ready, 1'b1);
		check_bit("retire_valid", retire_valid, 1'b0);
	endtask

	task automatic li_and_cmpi();
		word_t base;
		base = model_pc;
		place(base, li_word(3'd1, 8'h05));
		place(base + 16'd1, li_word(3'd2, 8'hff)); // Zero-extended to 0x00ff
		place(base + 16'd2, cmpi_word(3'd1, 8'h05));
		place(base + 16'd3, cmpi_word(3'd2, 8'hff));
		place(base + 16'd4, cmpi_word(3'd2, 8'h7f));
		run_program(5, 100);
	endtask

	task automatic conditional_branches();
		word_t base;
		base = model_pc;
		place(base, li_word(3'd0, 8'h00));
		place(base + 16'd1, li_word(3'd3, 8'h01));
		place(base + 16'd2, beqz_word(3'd0, 7));
		place(base + 16'd10, bnez_word(3'd0, 3)); // Not taken
		place(base + 16'd11, bnez_word(3'd3, -8));
		place(base + 16'd4, cmpi_word(3'd3, 8'h01));
		place(base + 16'd5, bteqz_word(10));
		place(base + 16'd16, beqz_word(3'd3, -3)); // Not taken
		place(base + 16'd17, b_word(-12));
		place(base + 16'd6, cmpi_word(3'd3, 8'h00));
		place(base + 16'd7, bteqz_word(-5)); // T set, falls through
		place(base + 16'd8, b_word(12));
		run_program(12, 100);
		check_word("fetch_pc", fetch_pc, base + 16'd21);
	endtask

	task automatic register_jumps();
		word_t base;
		base = model_pc;
		place(base, li_word(3'd4, 8'h40));
		place(base + 16'd1, jr_word(3'd4));
		place(16'h0040, li_word(3'd5, 8'h50));
		place(16'h0041, jalr_word(3'd5)); // Links 0x0042
		place(16'h0050, jrra_word());
		place(16'h0042, li_word(3'd6, 8'h60));
		place(16'h0043, jr_word(3'd6));
		run_program(7, 100);
		check_word("fetch_pc", fetch_pc, 16'h0060);
	endtask

	task automatic retire_stall();
		word_t       base;
		retire_rec_t held;
		bit          accepted;
		base = model_pc;
		place(base, li_word(3'd7, 8'h11));
		place(base + 16'd1, cmpi_word(3'd7, 8'h11));
		place(base + 16'd2, li_word(3'd1, 8'h22));
		drive_cycle(1'b1, 1'b0, accepted);
		held = exp_q[0]; // Predicted record of the first LI
		for (int i = 0; i < 6; i++) begin
			drive_cycle(1'b1, 1'b0, accepted);
			check_bit("instr_ready", instr_ready, 1'b0);
			check_word("retire_pc", retire_pc, held.pc);
			check_word("retire_next_pc", retire_next_pc, held.next_pc);
			check_target("retire_wb_target", retire_wb_target, held.tgt);
			check_reg("retire_wb_reg", retire_wb_reg, held.wreg);
			check_word("retire_wb_value", retire_wb_value, held.val);
		end
		run_program(2, 100);
		check_word("fetch_pc", fetch_pc, base + 16'd3);
	endtask

	function automatic instr_t random_instr();
		reg_idx_t r;
		int       off;
		instr_t   ins;
		r = reg_idx_t'($urandom % 4); // Few registers so compares often match
		off = int'($urandom % 3) + 1;
		case ($urandom % 6)
			0: ins = li_word(r, 8'($urandom % 4));
			1: ins = cmpi_word(r, 8'($urandom % 4));
			2: ins = b_word(off);
			3: ins = beqz_word(r, off);
			4: ins = bnez_word(r, off);
			default: ins = bteqz_word(off);
		endcase
		random_instr = ins;
	endfunction

	task automatic random_program();
		word_t base;
		base = model_pc;
		for (int i = 0; i < 200; i++) begin
			place(base + word_t'(i), random_instr());
		end
		run_program(40, 50);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		retire_ready = 1'b0;
		void'($urandom(70966));
		model_pc = `RESET_PC;
		model_t = 1'b0;
		model_ra = '0;
		for (int i = 0; i < `GPR_COUNT; i++) begin
			model_gpr[i] = '0;
		end
		for (int a = 0; a < 1024; a++) begin
			mem[a] = {5'b00001, 1'b0, a[9:0]}; // NOP fill
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		reset_values();
		li_and_cmpi();
		conditional_branches();
		register_jumps();
		retire_stall();
		random_program();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- flow_core.f
+incdir+logic
logic/isa_pkg.sv
logic/core_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/jmp_ctrl.sv
logic/fetch_unit.sv
logic/flow_core.sv
sim/flow_core_tb.sv

//--- Bender.yml
package:
  name: flow_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/isa_pkg.sv
      - logic/core_pkg.sv
      - logic/instr_decode.sv
      - logic/reg_file.sv
      - logic/jmp_ctrl.sv
      - logic/fetch_unit.sv
      - logic/flow_core.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/flow_core_tb.sv
